/* Bender.yml */
package:
  name: a25_wishbone

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/a25_wb_pkg.sv
      - hw/a25_wb_req_track.sv
      - hw/a25_wb_bus_seq.sv
      - hw/a25_wishbone.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/a25_wb_checker.sv
      - test/tb_a25_wishbone.sv

/* hw/a25_wb_bus_seq.sv */
// ==================================================
// wishbone cycle sequencer of the a25 master
// stb/cyc control, wrapping burst address and the
// ack counting that ends each access
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "a25_wb_settings.svh"

module a25_wb_bus_seq
(
    input  logic                         i_clk,
    input  logic                         quick_n_reset,
    input  logic                         i_start,
    input  a25_wb_pkg::wb_addr_u         i_adr,
    input  logic [`A25_WB_SEL_W-1:0]     i_sel,
    input  logic                         i_we,
    input  logic [`A25_WB_DATA_W-1:0]    i_wdata,
    input  logic                         i_qword,
    input  logic                         i_wb_ack,
    output logic [`A25_WB_DATA_W-1:0]    o_wb_adr,
    output logic [`A25_WB_SEL_W-1:0]     o_wb_sel,
    output logic                         o_wb_we,
    output logic [`A25_WB_DATA_W-1:0]    o_wb_dat,
    output logic                         o_wb_cyc,
    output logic                         o_wb_stb,
    output logic                         o_busy,
    output logic                         o_rd_ack,
    output logic                         o_last
);

    import a25_wb_pkg::*;

    wb_state_t   state_r;
    wb_addr_u    adr_r;
    logic        beat_ack;
    logic        in_burst;

    // ==================================================
    // ack decode
    // ==================================================
    // an ack only counts while our strobe is out
    assign beat_ack = o_wb_stb && i_wb_ack;

    assign in_burst = (state_r == WB_BURST1) || (state_r == WB_BURST2) ||
                      (state_r == WB_BURST3);

    // a posted write is acked in idle, every read ends in wait_ack
    assign o_last   = beat_ack && ((state_r == WB_IDLE) || (state_r == WB_WAIT_ACK));
    assign o_rd_ack = beat_ack && !o_wb_we;

    // the ack cycle of a posted write still counts as busy
    assign o_busy   = (state_r != WB_IDLE) || o_wb_stb;

    assign o_wb_adr = adr_r.flat;

    // ==================================================
    // state machine and strobe control
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r  <= WB_IDLE;
            o_wb_stb <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_we  <= 1'b0;
        end
        else
        begin
            case (state_r)
                WB_IDLE:
                begin
                    if (i_start)
                    begin
                        o_wb_stb <= 1'b1;
                        o_wb_cyc <= 1'b1;
                        o_wb_we  <= i_we;
                        // writes stay in idle, leaving the strobe out for its ack
                        if (i_we)
                            state_r <= WB_IDLE;
                        else if (i_qword)
                            state_r <= WB_BURST1;
                        else
                            state_r <= WB_WAIT_ACK;
                    end
                    else if (o_last)
                    begin
                        o_wb_stb <= 1'b0;
                        o_wb_cyc <= 1'b0;
                        o_wb_we  <= 1'b0;
                    end
                end
                WB_BURST1:
                begin
                    if (beat_ack)
                        state_r <= WB_BURST2;
                end
                WB_BURST2:
                begin
                    if (beat_ack)
                        state_r <= WB_BURST3;
                end
                WB_BURST3:
                begin
                    if (beat_ack)
                        state_r <= WB_WAIT_ACK;
                end
                WB_WAIT_ACK:
                begin
                    // the final ack closes the cycle on the next edge
                    if (o_last)
                    begin
                        state_r  <= WB_IDLE;
                        o_wb_stb <= 1'b0;
                        o_wb_cyc <= 1'b0;
                        o_wb_we  <= 1'b0;
                    end
                end
                default:
                begin
                    state_r <= WB_IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // address, select and write data
    // ==================================================
    // only the word field moves, so the burst wraps inside its line
    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            adr_r    <= i_adr;
            o_wb_sel <= i_sel;
            o_wb_dat <= i_wdata;
        end
        else if (beat_ack && in_burst)
        begin
            adr_r.f.word <= adr_r.f.word + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/a25_wb_pkg.sv */
// ==================================================
// shared types of the a25 wishbone master
// sequencer state, served request source and the
// bus address union with its line/word/byte view
// ==================================================
`default_nettype none

`include "a25_wb_settings.svh"

package a25_wb_pkg;

    // field widths follow the bus geometry
    localparam int WB_BYTE_W = $clog2(`A25_WB_SEL_W);
    localparam int WB_WORD_W = $clog2(`A25_WB_BURST_LEN);
    localparam int WB_LINE_W = `A25_WB_DATA_W - WB_WORD_W - WB_BYTE_W;

    // burst1..burst3 count the first three acks of a line fill
    typedef enum logic [2:0] {
        WB_IDLE, WB_BURST1, WB_BURST2, WB_BURST3, WB_WAIT_ACK
    } wb_state_t;

    typedef enum logic [1:0] {
        SRC_NONE, SRC_ICACHE, SRC_DCACHE_CACHED, SRC_DCACHE_UNCACHED
    } wb_src_t;

    // the same word is either the flat bus address or its cache-line fields
    typedef union packed {
        logic [`A25_WB_DATA_W-1:0] flat;
        struct packed {
            logic [WB_LINE_W-1:0] line;
            logic [WB_WORD_W-1:0] word;
            logic [WB_BYTE_W-1:0] byte_off;
        } f;
    } wb_addr_u;

endpackage

`default_nettype wire

/* hw/a25_wb_req_track.sv */
// ==================================================
// cache request tracker of the a25 wishbone master
// pending-request latches, dcache-first arbitration,
// bus request forming and ready steering
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "a25_wb_settings.svh"

module a25_wb_req_track
(
    input  logic                         i_clk,
    input  logic                         quick_n_reset,
    input  logic                         i_icache_req,
    input  logic                         i_icache_qword,
    input  logic [`A25_WB_DATA_W-1:0]    i_icache_address,
    input  logic                         i_dcache_cached_req,
    input  logic                         i_dcache_uncached_req,
    input  logic                         i_dcache_qword,
    input  logic                         i_dcache_write,
    input  logic [`A25_WB_DATA_W-1:0]    i_dcache_write_data,
    input  logic [`A25_WB_SEL_W-1:0]     i_dcache_byte_enable,
    input  logic [`A25_WB_DATA_W-1:0]    i_dcache_address,
    input  logic                         i_busy,
    input  logic                         i_rd_ack,
    input  logic                         i_last,
    output logic                         o_start,
    output a25_wb_pkg::wb_addr_u         o_adr,
    output logic [`A25_WB_SEL_W-1:0]     o_sel,
    output logic                         o_we,
    output logic [`A25_WB_DATA_W-1:0]    o_wdata,
    output logic                         o_qword,
    output logic                         o_icache_ready,
    output logic                         o_dcache_cached_ready,
    output logic                         o_dcache_uncached_ready
);

    import a25_wb_pkg::*;

    logic                        pend_icache_r;
    logic                        pend_dc_cached_r;
    logic                        pend_dc_uncached_r;
    logic                        icache_qword_r;
    logic [`A25_WB_DATA_W-1:0]   icache_adr_r;
    logic                        icache_req_c;
    logic                        dc_cached_req_c;
    logic                        dc_uncached_req_c;
    logic                        icache_qword_c;
    logic [`A25_WB_DATA_W-1:0]   icache_adr_c;
    wb_src_t                     sel_src;
    wb_src_t                     src_r;
    logic                        dc_sel;
    logic                        wr_launch;
    logic [WB_BYTE_W-1:0]        byte_off;

    // ==================================================
    // request merge and arbitration
    // ==================================================
    // a live level or a remembered one both count as a request
    assign icache_req_c      = i_icache_req || pend_icache_r;
    assign dc_cached_req_c   = i_dcache_cached_req || pend_dc_cached_r;
    assign dc_uncached_req_c = i_dcache_uncached_req || pend_dc_uncached_r;

    assign icache_qword_c = i_icache_req ? i_icache_qword : icache_qword_r;
    assign icache_adr_c   = i_icache_req ? i_icache_address : icache_adr_r;

    // data side always wins over instruction fetch
    always_comb
    begin
        if (dc_cached_req_c)
            sel_src = SRC_DCACHE_CACHED;
        else if (dc_uncached_req_c)
            sel_src = SRC_DCACHE_UNCACHED;
        else if (icache_req_c)
            sel_src = SRC_ICACHE;
        else
            sel_src = SRC_NONE;
    end

    // the sequencer takes a new access only while it reports free
    assign o_start   = !i_busy && (sel_src != SRC_NONE);
    assign dc_sel    = (sel_src == SRC_DCACHE_CACHED) || (sel_src == SRC_DCACHE_UNCACHED);
    assign o_we      = dc_sel && i_dcache_write;
    assign o_wdata   = i_dcache_write_data;
    assign o_sel     = o_we ? i_dcache_byte_enable : '1;
    assign o_qword   = dc_sel ? (i_dcache_qword && !i_dcache_write) : icache_qword_c;
    assign wr_launch = o_start && o_we;

    // low address bits come from the lane pattern, reads land on 0
    always_comb
    begin
        case (o_sel)
            4'b0001: byte_off = 2'd0;
            4'b0010: byte_off = 2'd1;
            4'b0100: byte_off = 2'd2;
            4'b1000: byte_off = 2'd3;
            4'b1100: byte_off = 2'd2;
            default: byte_off = 2'd0;
        endcase
    end

    always_comb
    begin
        o_adr.flat       = dc_sel ? i_dcache_address : icache_adr_c;
        o_adr.f.byte_off = byte_off;
    end

    // ==================================================
    // ready steering
    // ==================================================
    // posted writes are ready at launch, reads on every read ack
    assign o_icache_ready          = (src_r == SRC_ICACHE) && i_rd_ack;
    assign o_dcache_cached_ready   = ((src_r == SRC_DCACHE_CACHED) && i_rd_ack) ||
                                     (wr_launch && (sel_src == SRC_DCACHE_CACHED));
    assign o_dcache_uncached_ready = ((src_r == SRC_DCACHE_UNCACHED) && i_rd_ack) ||
                                     (wr_launch && (sel_src == SRC_DCACHE_UNCACHED));

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            pend_icache_r      <= 1'b0;
            pend_dc_cached_r   <= 1'b0;
            pend_dc_uncached_r <= 1'b0;
            src_r              <= SRC_NONE;
        end
        else
        begin
            // a request is forgotten once its access has ended or a write has launched
            pend_icache_r      <= icache_req_c && !((src_r == SRC_ICACHE) && i_last);
            pend_dc_cached_r   <= dc_cached_req_c &&
                                  !(((src_r == SRC_DCACHE_CACHED) && i_last) ||
                                    (wr_launch && (sel_src == SRC_DCACHE_CACHED)));
            pend_dc_uncached_r <= dc_uncached_req_c &&
                                  !(((src_r == SRC_DCACHE_UNCACHED) && i_last) ||
                                    (wr_launch && (sel_src == SRC_DCACHE_UNCACHED)));
            if (i_last)
                src_r <= SRC_NONE;
            else if (o_start)
                src_r <= sel_src;
        end
    end

    // the fetch address is kept in case the live level goes away
    always_ff @(posedge i_clk)
    begin
        if (i_icache_req)
        begin
            icache_adr_r   <= i_icache_address;
            icache_qword_r <= i_icache_qword;
        end
    end

endmodule

`default_nettype wire

/* hw/a25_wishbone.sv */
// ==================================================
// a25 wishbone master top level
// joins the request tracker and the cycle sequencer
// to the cache ports and the wishbone bus
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "a25_wb_settings.svh"

module a25_wishbone
(
    input  logic                         i_clk,
    input  logic                         quick_n_reset,

    // instruction cache side
    input  logic                         i_icache_req,
    input  logic                         i_icache_qword,
    input  logic [`A25_WB_DATA_W-1:0]    i_icache_address,
    output logic [`A25_WB_DATA_W-1:0]    o_icache_read_data,
    output logic                         o_icache_ready,

    // data cache side, byte enables matter for writes only
    input  logic                         i_dcache_cached_req,
    input  logic                         i_dcache_uncached_req,
    input  logic                         i_dcache_qword,
    input  logic                         i_dcache_write,
    input  logic [`A25_WB_DATA_W-1:0]    i_dcache_write_data,
    input  logic [`A25_WB_SEL_W-1:0]     i_dcache_byte_enable,
    input  logic [`A25_WB_DATA_W-1:0]    i_dcache_address,
    output logic [`A25_WB_DATA_W-1:0]    o_dcache_read_data,
    output logic                         o_dcache_cached_ready,
    output logic                         o_dcache_uncached_ready,

    // wishbone master port
    output logic [`A25_WB_DATA_W-1:0]    o_wb_adr,
    output logic [`A25_WB_SEL_W-1:0]     o_wb_sel,
    output logic                         o_wb_we,
    input  logic [`A25_WB_DATA_W-1:0]    i_wb_dat,
    output logic [`A25_WB_DATA_W-1:0]    o_wb_dat,
    output logic                         o_wb_cyc,
    output logic                         o_wb_stb,
    input  logic                         i_wb_ack
);

    import a25_wb_pkg::*;

    logic                        start;
    wb_addr_u                    req_adr;
    logic [`A25_WB_SEL_W-1:0]    req_sel;
    logic                        req_we;
    logic [`A25_WB_DATA_W-1:0]   req_wdata;
    logic                        req_qword;
    logic                        seq_busy;
    logic                        seq_rd_ack;
    logic                        seq_last;

    // read data is taken straight off the bus, the ready pulse qualifies it
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    a25_wb_req_track u_req_track (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache_req            (i_icache_req),
        .i_icache_qword          (i_icache_qword),
        .i_icache_address        (i_icache_address),
        .i_dcache_cached_req     (i_dcache_cached_req),
        .i_dcache_uncached_req   (i_dcache_uncached_req),
        .i_dcache_qword          (i_dcache_qword),
        .i_dcache_write          (i_dcache_write),
        .i_dcache_write_data     (i_dcache_write_data),
        .i_dcache_byte_enable    (i_dcache_byte_enable),
        .i_dcache_address        (i_dcache_address),
        .i_busy                  (seq_busy),
        .i_rd_ack                (seq_rd_ack),
        .i_last                  (seq_last),
        .o_start                 (start),
        .o_adr                   (req_adr),
        .o_sel                   (req_sel),
        .o_we                    (req_we),
        .o_wdata                 (req_wdata),
        .o_qword                 (req_qword),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready)
    );

    a25_wb_bus_seq u_bus_seq (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_adr         (req_adr),
        .i_sel         (req_sel),
        .i_we          (req_we),
        .i_wdata       (req_wdata),
        .i_qword       (req_qword),
        .i_wb_ack      (i_wb_ack),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_busy        (seq_busy),
        .o_rd_ack      (seq_rd_ack),
        .o_last        (seq_last)
    );

endmodule

`default_nettype wire

/* include/a25_wb_settings.svh */
// ==================================================
// bus geometry for the a25 wishbone master
// data and address width, byte lanes, burst length
// and the seed of the random testbench
// ==================================================
`ifndef A25_WB_SETTINGS_SVH
`define A25_WB_SETTINGS_SVH

// address and data share one width on this bus
`define A25_WB_DATA_W    32

// one select bit per byte lane
`define A25_WB_SEL_W     4

// words in one cache line, which is one wrapping burst
`define A25_WB_BURST_LEN 4

`define A25_WB_SEED      32'hc1d4

`endif

/* tb.f */
+incdir+include
hw/a25_wb_pkg.sv
hw/a25_wb_req_track.sv
hw/a25_wb_bus_seq.sv
hw/a25_wishbone.sv
test/a25_wb_checker.sv
test/tb_a25_wishbone.sv

/* test/a25_wb_checker.sv */
// ==================================================
// wishbone protocol and state-sequence assertions
// bound into the a25 cycle sequencer
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "a25_wb_settings.svh"

module a25_wb_checker
(
    input  logic                         i_clk,
    input  logic                         quick_n_reset,
    input  logic                         i_stb,
    input  logic                         i_cyc,
    input  logic                         i_ack,
    input  logic                         i_we,
    input  logic [`A25_WB_DATA_W-1:0]    i_adr,
    input  logic [`A25_WB_SEL_W-1:0]     i_sel,
    input  logic [`A25_WB_DATA_W-1:0]    i_dat,
    input  a25_wb_pkg::wb_state_t        i_state
);

    import a25_wb_pkg::*;

    // protocol violations seen so far
    int fail_cnt = 0;

    // a strobe is never out without its cycle
    a_stb_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_stb |-> i_cyc)
        else
        begin
            fail_cnt++;
            $error("stb high without cyc");
        end

    // back-pressure freezes every bus output
    a_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_stb && !i_ack) |=> (i_stb && $stable(i_adr) && $stable(i_sel) &&
                               $stable(i_we) && $stable(i_dat)))
        else
        begin
            fail_cnt++;
            $error("bus outputs moved while waiting for ack");
        end

    // synchronous reset leaves the bus quiet and the FSM idle
    a_reset: assert property (@(posedge i_clk)
        !quick_n_reset |=> (!i_stb && !i_cyc && i_state == WB_IDLE))
        else
        begin
            fail_cnt++;
            $error("bus not quiet after reset");
        end

    a_seq_idle: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_state == WB_IDLE |=> i_state inside {WB_IDLE, WB_BURST1, WB_WAIT_ACK})
        else
        begin
            fail_cnt++;
            $error("illegal step out of idle");
        end

    a_seq_b1: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_state == WB_BURST1 |=> i_state inside {WB_BURST1, WB_BURST2})
        else
        begin
            fail_cnt++;
            $error("illegal step out of burst1");
        end

    a_seq_b2: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_state == WB_BURST2 |=> i_state inside {WB_BURST2, WB_BURST3})
        else
        begin
            fail_cnt++;
            $error("illegal step out of burst2");
        end

    a_seq_b3: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_state == WB_BURST3 |=> i_state inside {WB_BURST3, WB_WAIT_ACK})
        else
        begin
            fail_cnt++;
            $error("illegal step out of burst3");
        end

    a_seq_wait: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_state == WB_WAIT_ACK |=> i_state inside {WB_WAIT_ACK, WB_IDLE})
        else
        begin
            fail_cnt++;
            $error("illegal step out of wait_ack");
        end

    // the ending ack of a read or a posted write drops stb and cyc on the next edge
    a_end: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state inside {WB_IDLE, WB_WAIT_ACK} && i_stb && i_ack) |=> !i_stb && !i_cyc)
        else
        begin
            fail_cnt++;
            $error("stb still high after the final ack");
        end

endmodule

bind a25_wb_bus_seq a25_wb_checker u_checker (
    .i_clk         (i_clk),
    .quick_n_reset (quick_n_reset),
    .i_stb         (o_wb_stb),
    .i_cyc         (o_wb_cyc),
    .i_ack         (i_wb_ack),
    .i_we          (o_wb_we),
    .i_adr         (o_wb_adr),
    .i_sel         (o_wb_sel),
    .i_dat         (o_wb_dat),
    .i_state       (state_r)
);

`default_nettype wire

/* test/tb_a25_wishbone.sv */
// ==================================================
// testbench of the a25 wishbone master
// clock, reset, random-wait slave, cache stimulus,
// scoreboard assertions and the run timeout
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "a25_wb_settings.svh"

module tb_a25_wishbone;

    localparam logic [31:0] PAT      = 32'h5a5a_c3c3;
    localparam int          WAIT_MAX = 3;
    localparam int          NUM_ACC  = 20;
    localparam int          LIMIT    = 20 * NUM_ACC * (WAIT_MAX + 1);

    logic        clk, rst_n;
    logic        ic_req, ic_qword, ic_rdy;
    logic [31:0] ic_adr, ic_rdata;
    logic        dc_creq, dc_ureq, dc_qword, dc_write, dc_crdy, dc_urdy;
    logic [31:0] dc_wdata, dc_adr, dc_rdata;
    logic [3:0]  dc_be;
    logic [31:0] wb_adr, wb_dat_o, wb_dat_i;
    logic [3:0]  wb_sel;
    logic        wb_we, wb_cyc, wb_stb, wb_ack;

    // expected values held by the stimulus between falling edges
    logic        ic_active = 0, dc_active = 0, dc_cached = 0;
    logic [31:0] exp_ic_adr = 0, exp_dc_adr = 0, exp_wr_adr = 0, exp_wr_dat = 0;
    logic [3:0]  exp_wr_sel = 0;
    int          errors = 0, cycles = 0, wait_cnt = 0, writes_seen = 0, writes_sent = 0;
    int          seed;

    a25_wishbone u_dut (
        .i_clk(clk), .quick_n_reset(rst_n),
        .i_icache_req(ic_req), .i_icache_qword(ic_qword), .i_icache_address(ic_adr),
        .o_icache_read_data(ic_rdata), .o_icache_ready(ic_rdy),
        .i_dcache_cached_req(dc_creq), .i_dcache_uncached_req(dc_ureq),
        .i_dcache_qword(dc_qword), .i_dcache_write(dc_write),
        .i_dcache_write_data(dc_wdata), .i_dcache_byte_enable(dc_be),
        .i_dcache_address(dc_adr), .o_dcache_read_data(dc_rdata),
        .o_dcache_cached_ready(dc_crdy), .o_dcache_uncached_ready(dc_urdy),
        .o_wb_adr(wb_adr), .o_wb_sel(wb_sel), .o_wb_we(wb_we), .i_wb_dat(wb_dat_i),
        .o_wb_dat(wb_dat_o), .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .i_wb_ack(wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // byte offset that a write's lane pattern puts on the bus
    function automatic logic [1:0] lane_offset(input logic [3:0] be);
        case (be)
            4'b0010: return 2'd1;
            4'b0100, 4'b1100: return 2'd2;
            4'b1000: return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    // ==================================================
    // slave model with 0 to 3 wait cycles
    // ==================================================
    always @(negedge clk)
    begin
        if (wb_stb && !wb_ack && rst_n)
        begin
            if (wait_cnt == 0)
            begin
                wb_ack   <= 1'b1;
                wb_dat_i <= wb_adr ^ PAT;
                wait_cnt <= $urandom_range(WAIT_MAX, 0);
                if (wb_we)
                    writes_seen++;
            end
            else
                wait_cnt <= wait_cnt - 1;
        end
        else
            wb_ack <= 1'b0;
    end

    // ==================================================
    // scoreboard assertions
    // ==================================================
    a_ic_data: assert property (@(posedge clk) disable iff (!rst_n)
        ic_rdy |-> (wb_adr == exp_ic_adr && ic_rdata == (exp_ic_adr ^ PAT)))
        else
        begin
            errors++;
            $display("Mismatch o_wb_adr/o_icache_read_data: %h/%h expected %h/%h",
                     $sampled(wb_adr), $sampled(ic_rdata), exp_ic_adr, exp_ic_adr ^ PAT);
        end

    // fetches never overtake a pending data access
    a_ic_order: assert property (@(posedge clk) disable iff (!rst_n)
        ic_rdy |-> (ic_active && !dc_active))
        else
        begin
            errors++;
            $display("icache ready came while not expected or before dcache");
        end

    a_dc_data: assert property (@(posedge clk) disable iff (!rst_n)
        ((dc_crdy || dc_urdy) && !dc_write) |->
            (wb_adr == exp_dc_adr && dc_rdata == (exp_dc_adr ^ PAT)))
        else
        begin
            errors++;
            $display("Mismatch o_wb_adr/o_dcache_read_data: %h/%h expected %h/%h",
                     $sampled(wb_adr), $sampled(dc_rdata), exp_dc_adr, exp_dc_adr ^ PAT);
        end

    a_dc_line: assert property (@(posedge clk) disable iff (!rst_n)
        (dc_crdy || dc_urdy) |-> (dc_active && dc_crdy == dc_cached && dc_urdy == !dc_cached))
        else
        begin
            errors++;
            $display("dcache ready came on the wrong line or unexpectedly");
        end

    // every read uses all four byte lanes
    a_rd_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_we) |-> wb_sel == 4'hf)
        else
        begin
            errors++;
            $display("Mismatch o_wb_sel: %h expected %h", $sampled(wb_sel), 4'hf);
        end

    // cyc is never held between cycles and follows stb exactly
    a_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc == wb_stb)
        else
        begin
            errors++;
            $display("Mismatch o_wb_cyc: %h expected %h", $sampled(wb_cyc), $sampled(wb_stb));
        end

    // a posted write is ready while the bus is still free and strobes on the next cycle
    a_wr_post: assert property (@(posedge clk) disable iff (!rst_n)
        ((dc_crdy || dc_urdy) && dc_write) |-> !wb_stb ##1 (wb_stb && wb_we))
        else
        begin
            errors++;
            $display("write ready pulse not in its launch cycle");
        end

    a_wr_adr: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_we) |-> wb_adr == exp_wr_adr)
        else
        begin
            errors++;
            $display("Mismatch o_wb_adr: %h expected %h", $sampled(wb_adr), exp_wr_adr);
        end

    a_wr_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_we) |-> wb_sel == exp_wr_sel)
        else
        begin
            errors++;
            $display("Mismatch o_wb_sel: %h expected %h", $sampled(wb_sel), exp_wr_sel);
        end

    a_wr_dat: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_we) |-> wb_dat_o == exp_wr_dat)
        else
        begin
            errors++;
            $display("Mismatch o_wb_dat: %h expected %h", $sampled(wb_dat_o), exp_wr_dat);
        end

    // ==================================================
    // cache-side stimulus
    // ==================================================
    task automatic ic_read(input logic [31:0] adr, input logic qword);
        int n = 0;
        @(negedge clk);
        ic_req = 1'b1;
        ic_qword = qword;
        ic_adr = adr;
        ic_active = 1'b1;
        exp_ic_adr = {adr[31:2], 2'b00};
        forever
        begin
            @(posedge clk);
            if (ic_rdy)
            begin
                n++;
                @(negedge clk);
                if (n == (qword ? `A25_WB_BURST_LEN : 1))
                    break;
                exp_ic_adr[3:2] = exp_ic_adr[3:2] + 2'd1;
            end
        end
        ic_req = 1'b0;
        ic_active = 1'b0;
    endtask

    task automatic dc_read(input logic [31:0] adr, input logic qword, input logic cached);
        int n = 0;
        @(negedge clk);
        dc_creq = cached;
        dc_ureq = !cached;
        dc_qword = qword;
        dc_write = 1'b0;
        dc_be = 4'hf;
        dc_adr = adr;
        dc_active = 1'b1;
        dc_cached = cached;
        exp_dc_adr = {adr[31:2], 2'b00};
        forever
        begin
            @(posedge clk);
            if (dc_crdy || dc_urdy)
            begin
                n++;
                @(negedge clk);
                if (n == (qword ? `A25_WB_BURST_LEN : 1))
                    break;
                exp_dc_adr[3:2] = exp_dc_adr[3:2] + 2'd1;
            end
        end
        dc_creq = 1'b0;
        dc_ureq = 1'b0;
        dc_active = 1'b0;
    endtask

    // a write is followed to its bus ack before the next request is raised
    task automatic dc_wr(input logic [31:0] adr, input logic [31:0] data,
                         input logic [3:0] be, input logic cached);
        @(negedge clk);
        dc_creq = cached;
        dc_ureq = !cached;
        dc_qword = 1'b0;
        dc_write = 1'b1;
        dc_be = be;
        dc_adr = adr;
        dc_wdata = data;
        dc_active = 1'b1;
        dc_cached = cached;
        exp_wr_adr = {adr[31:2], lane_offset(be)};
        exp_wr_sel = be;
        exp_wr_dat = data;
        writes_sent++;
        do @(posedge clk); while (!(dc_crdy || dc_urdy));
        @(negedge clk);
        dc_creq = 1'b0;
        dc_ureq = 1'b0;
        dc_active = 1'b0;
        do @(posedge clk); while (!(wb_stb && wb_we && wb_ack));
        @(negedge clk);
        dc_write = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial
    begin
        logic [3:0] be_list [6];
        int k;
        seed = `A25_WB_SEED;
        void'($urandom(seed));
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1100, 4'b0011};
        rst_n = 1'b0;
        wb_ack = 1'b0;
        wb_dat_i = '0;
        ic_req = 1'b0;
        ic_qword = 1'b0;
        ic_adr = '0;
        dc_creq = 1'b0;
        dc_ureq = 1'b0;
        dc_qword = 1'b0;
        dc_write = 1'b0;
        dc_wdata = '0;
        dc_be = '0;
        dc_adr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        ic_read(32'h0000_1004, 1'b0);
        dc_read(32'h8000_0208, 1'b0, 1'b0);
        ic_read(32'h0000_2048, 1'b1);
        dc_read(32'h4000_0134, 1'b1, 1'b1);
        for (k = 0; k < 6; k++)
            dc_wr(32'h2000_0010 + 32'(k * 4), $urandom(), be_list[k], k[0]);
        fork
            dc_read(32'h3000_0440, 1'b0, 1'b0);
            ic_read(32'h0000_3008, 1'b0);
        join
        for (k = 0; k < 8; k++)
        begin
            case ($urandom_range(2, 0))
                0: ic_read($urandom(), 1'($urandom()));
                1: dc_read($urandom(), 1'($urandom()), 1'($urandom()));
                default: dc_wr($urandom(), $urandom(), be_list[$urandom_range(5, 0)], 1'b1);
            endcase
        end
        repeat (4) @(posedge clk);
        a_writes: assert (writes_seen == writes_sent)
        else
        begin
            errors++;
            $display("Mismatch slave write count: %h expected %h", writes_seen, writes_sent);
        end

        $display("errors: testbench %0d, checker %0d", errors, u_dut.u_bus_seq.u_checker.fail_cnt);
        if (errors == 0 && u_dut.u_bus_seq.u_checker.fail_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
